// ==== logic/stream_params.svh ====
// Size definitions shared by the stream bridge and its configuration block
// Include wherever a stream or configuration width is needed

`ifndef STREAM_PARAMS_SVH
`define STREAM_PARAMS_SVH

// Data path, 32-bit beats
`define STREAM_DATA_BYTES 4
`define STREAM_EMPTY_WIDTH 2

// Channel count and width of channel / tid
`define STREAM_CHANNELS 4
`define STREAM_CHANNEL_WIDTH 2

// Sideband fields driven from the route table
`define STREAM_DEST_WIDTH 4
`define STREAM_USER_WIDTH 4

// Configuration port
`define CFG_ADDR_WIDTH 3
`define CFG_DATA_WIDTH 32

`endif

// ==== logic/stream_pkg.sv ====
// Types and address map for the stream bridge configuration port
// Modules take these in by a wildcard import in their header

`include "stream_params.svh"

package stream_pkg;

    // Route entry layout, one per channel
    typedef struct packed {
        logic [`CFG_DATA_WIDTH-`STREAM_USER_WIDTH-`STREAM_DEST_WIDTH-1:0] reserved;
        logic [`STREAM_USER_WIDTH-1:0] user;
        logic [`STREAM_DEST_WIDTH-1:0] dest;
    } cfg_route_t;

    // Control word layout, one enable bit per channel
    typedef struct packed {
        logic [`CFG_DATA_WIDTH-`STREAM_CHANNELS-1:0] reserved;
        logic [`STREAM_CHANNELS-1:0] channel_enable;
    } cfg_ctrl_t;

    // Same configuration word, decoded by address
    typedef union packed {
        cfg_route_t route;
        cfg_ctrl_t ctrl;
    } cfg_word_u;

    // Control word first, route entry n at base plus n
    localparam logic [`CFG_ADDR_WIDTH-1:0] CFG_ADDR_CTRL = 'd0;
    localparam logic [`CFG_ADDR_WIDTH-1:0] CFG_ADDR_ROUTE_BASE = 'd1;

endpackage

// ==== logic/route_config.sv ====
// Configuration registers for the stream bridge
// Holds the per-channel enable bits and the per-channel tdest/tuser routes
// Written by a single-cycle strobe, read back combinationally

`timescale 1ns/1ns

`include "stream_params.svh"

module route_config import stream_pkg::*; (
    input  logic aclk,
    input  logic areset_n,
    // Strobe write port, no back-pressure
    input  logic cfg_wr,
    input  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  cfg_word_u cfg_wdata,
    output cfg_word_u cfg_rdata,
    // Settings towards the bridge
    output logic [`STREAM_CHANNELS-1:0] channel_enable,
    output logic [`STREAM_CHANNELS*`STREAM_DEST_WIDTH-1:0] route_dest,
    output logic [`STREAM_CHANNELS*`STREAM_USER_WIDTH-1:0] route_user
);
    logic ctrl_hit;
    logic [`STREAM_CHANNELS-1:0] route_hit;

    // Address decode
    // Anything above the last route entry hits nothing
    always_comb begin
        ctrl_hit = (cfg_addr == CFG_ADDR_CTRL);
        for (int n = 0; n < `STREAM_CHANNELS; n++) begin
            route_hit[n] = (int'(cfg_addr) == int'(CFG_ADDR_ROUTE_BASE) + n);
        end
    end

    // Register update on the strobe
    // Control view at the control address, route view at the route addresses
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            // All channels pass, all routes zero
            channel_enable <= '1;
            route_dest <= '0;
            route_user <= '0;
        end
        else if (cfg_wr) begin
            if (ctrl_hit) begin
                channel_enable <= cfg_wdata.ctrl.channel_enable;
            end
            for (int n = 0; n < `STREAM_CHANNELS; n++) begin
                if (route_hit[n]) begin
                    route_dest[n*`STREAM_DEST_WIDTH +: `STREAM_DEST_WIDTH] <=
                        cfg_wdata.route.dest;
                    route_user[n*`STREAM_USER_WIDTH +: `STREAM_USER_WIDTH] <=
                        cfg_wdata.route.user;
                end
            end
        end
    end

    // Readback mux
    // Start from zero so reserved bits and unused addresses read zero
    always_comb begin
        cfg_rdata = '0;
        if (ctrl_hit) begin
            cfg_rdata.ctrl.channel_enable = channel_enable;
        end
        for (int n = 0; n < `STREAM_CHANNELS; n++) begin
            if (route_hit[n]) begin
                cfg_rdata.route.dest =
                    route_dest[n*`STREAM_DEST_WIDTH +: `STREAM_DEST_WIDTH];
                cfg_rdata.route.user =
                    route_user[n*`STREAM_USER_WIDTH +: `STREAM_USER_WIDTH];
            end
        end
    end

    // A write strobe must come with a known address
    // otherwise the decode above silently picks nothing or the wrong entry
    cfg_addr_known: assert property (
        @(posedge aclk) disable iff (!areset_n)
        cfg_wr |-> !$isunknown(cfg_addr)
    ) else $error("cfg_addr unknown during cfg_wr");

endmodule

// ==== logic/avalon_to_axis.sv ====
// Avalon-ST to AXI4-Stream bridge with one registered output stage
// Channel maps to tid, empty maps to a byte strobe, endofpacket to tlast
// tdest and tuser come from the per-channel route table
// Beats on a disabled channel are accepted and dropped

`timescale 1ns/1ns

`include "stream_params.svh"

module avalon_to_axis import stream_pkg::*; (
    input  logic aclk,
    input  logic areset_n,
    // Avalon-ST sink side
    input  logic rx_valid,
    output logic rx_ready,
    input  logic [`STREAM_DATA_BYTES*8-1:0] rx_data,
    input  logic [`STREAM_CHANNEL_WIDTH-1:0] rx_channel,
    input  logic [`STREAM_EMPTY_WIDTH-1:0] rx_empty,
    input  logic rx_endofpacket,
    // AXI4-Stream source side
    output logic tx_tvalid,
    input  logic tx_tready,
    output logic [`STREAM_DATA_BYTES*8-1:0] tx_tdata,
    output logic [`STREAM_DATA_BYTES-1:0] tx_tstrb,
    output logic [`STREAM_DATA_BYTES-1:0] tx_tkeep,
    output logic tx_tlast,
    output logic [`STREAM_CHANNEL_WIDTH-1:0] tx_tid,
    output logic [`STREAM_DEST_WIDTH-1:0] tx_tdest,
    output logic [`STREAM_USER_WIDTH-1:0] tx_tuser,
    // Settings from the configuration block
    input  logic [`STREAM_CHANNELS-1:0] channel_enable,
    input  logic [`STREAM_CHANNELS*`STREAM_DEST_WIDTH-1:0] route_dest,
    input  logic [`STREAM_CHANNELS*`STREAM_USER_WIDTH-1:0] route_user
);
    logic [`STREAM_DATA_BYTES-1:0] strb;
    logic chan_on;
    logic [`STREAM_DEST_WIDTH-1:0] dest_sel;
    logic [`STREAM_USER_WIDTH-1:0] user_sel;

    // Output register moves only when the sink takes data
    // so the source may only hand over a beat at the same time
    assign rx_ready = tx_tready;

    // Every byte position is a data byte, strobe tells which are valid
    assign tx_tkeep = '1;

    // Empty counts unused bytes at the top, low-order bytes stay valid
    always_comb begin
        strb = '1;
        strb = strb >> rx_empty;
    end

    // Route lookup for the incoming beat's channel
    // uses the table as it stands at the accepting edge
    always_comb begin
        chan_on = channel_enable[rx_channel];
        dest_sel = route_dest[rx_channel*`STREAM_DEST_WIDTH +: `STREAM_DEST_WIDTH];
        user_sel = route_user[rx_channel*`STREAM_USER_WIDTH +: `STREAM_USER_WIDTH];
    end

    // Valid register
    // A disabled channel still gets rx_ready, its beat just never shows on tx
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            tx_tvalid <= 1'b0;
        end
        else if (tx_tready) begin
            tx_tvalid <= rx_valid && chan_on;
        end
    end

    // Payload registers, only meaningful while tx_tvalid is high
    always_ff @(posedge aclk) begin
        if (tx_tready) begin
            tx_tdata <= rx_data;
            tx_tstrb <= strb;
            tx_tlast <= rx_endofpacket;
            tx_tid <= rx_channel;
            tx_tdest <= dest_sel;
            tx_tuser <= user_sel;
        end
    end

    // Stalled beat must hold still until the sink takes it
    tx_hold_stable: assert property (
        @(posedge aclk) disable iff (!areset_n)
        (tx_tvalid && !tx_tready) |=>
            (tx_tvalid && $stable({tx_tdata, tx_tstrb, tx_tlast,
                                   tx_tid, tx_tdest, tx_tuser}))
    ) else $error("tx beat changed under back-pressure");

    // An empty count never covers the whole word
    tx_strb_nonzero: assert property (
        @(posedge aclk) disable iff (!areset_n)
        tx_tvalid |-> (tx_tstrb != '0)
    ) else $error("tx_tstrb zero on a valid beat");

endmodule

// ==== logic/stream_bridge_top.sv ====
// Top level of the stream bridge subsystem
// Joins the configuration registers to the Avalon-ST to AXI4-Stream bridge

`timescale 1ns/1ns

`include "stream_params.svh"

module stream_bridge_top import stream_pkg::*; (
    input  logic aclk,
    input  logic areset_n,
    // Configuration port
    input  logic cfg_wr,
    input  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  cfg_word_u cfg_wdata,
    output cfg_word_u cfg_rdata,
    // Avalon-ST input
    input  logic rx_valid,
    output logic rx_ready,
    input  logic [`STREAM_DATA_BYTES*8-1:0] rx_data,
    input  logic [`STREAM_CHANNEL_WIDTH-1:0] rx_channel,
    input  logic [`STREAM_EMPTY_WIDTH-1:0] rx_empty,
    input  logic rx_endofpacket,
    // AXI4-Stream output
    output logic tx_tvalid,
    input  logic tx_tready,
    output logic [`STREAM_DATA_BYTES*8-1:0] tx_tdata,
    output logic [`STREAM_DATA_BYTES-1:0] tx_tstrb,
    output logic [`STREAM_DATA_BYTES-1:0] tx_tkeep,
    output logic tx_tlast,
    output logic [`STREAM_CHANNEL_WIDTH-1:0] tx_tid,
    output logic [`STREAM_DEST_WIDTH-1:0] tx_tdest,
    output logic [`STREAM_USER_WIDTH-1:0] tx_tuser
);
    // Settings from the register block into the bridge
    logic [`STREAM_CHANNELS-1:0] channel_enable;
    logic [`STREAM_CHANNELS*`STREAM_DEST_WIDTH-1:0] route_dest;
    logic [`STREAM_CHANNELS*`STREAM_USER_WIDTH-1:0] route_user;

    route_config cfg_i (
        .aclk, .areset_n,
        .cfg_wr, .cfg_addr, .cfg_wdata, .cfg_rdata,
        .channel_enable, .route_dest, .route_user
    );

    avalon_to_axis bridge_i (
        .aclk, .areset_n,
        .rx_valid, .rx_ready, .rx_data, .rx_channel, .rx_empty, .rx_endofpacket,
        .tx_tvalid, .tx_tready, .tx_tdata, .tx_tstrb, .tx_tkeep, .tx_tlast,
        .tx_tid, .tx_tdest, .tx_tuser,
        .channel_enable, .route_dest, .route_user
    );

endmodule

// ==== bench/bridge_checker.sv ====
// Checker for the stream bridge testbench
// Models the configuration registers, predicts every tx beat, compares at each edge
// Prints one line per finished test and exports the counts to the testbench top

`timescale 1ns/1ns

`include "stream_params.svh"

module bridge_checker import stream_pkg::*; (
    input  logic aclk,
    input  logic areset_n,
    input  logic cfg_wr,
    input  logic [`CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [`CFG_DATA_WIDTH-1:0] cfg_wdata,
    input  logic [`CFG_DATA_WIDTH-1:0] cfg_rdata,
    input  logic rx_valid,
    input  logic rx_ready,
    input  logic [`STREAM_DATA_BYTES*8-1:0] rx_data,
    input  logic [`STREAM_CHANNEL_WIDTH-1:0] rx_channel,
    input  logic [`STREAM_EMPTY_WIDTH-1:0] rx_empty,
    input  logic rx_endofpacket,
    input  logic tx_tvalid,
    input  logic tx_tready,
    input  logic [`STREAM_DATA_BYTES*8-1:0] tx_tdata,
    input  logic [`STREAM_DATA_BYTES-1:0] tx_tstrb,
    input  logic [`STREAM_DATA_BYTES-1:0] tx_tkeep,
    input  logic tx_tlast,
    input  logic [`STREAM_CHANNEL_WIDTH-1:0] tx_tid,
    input  logic [`STREAM_DEST_WIDTH-1:0] tx_tdest,
    input  logic [`STREAM_USER_WIDTH-1:0] tx_tuser,
    // Test boundary from the testbench top
    input  logic test_end,
    input  int test_num,
    output int error_count,
    output int check_count,
    output int beats_compared,
    output int pending
);
    typedef struct packed {
        logic [`STREAM_DATA_BYTES*8-1:0] data;
        logic [`STREAM_DATA_BYTES-1:0] strb;
        logic [`STREAM_DATA_BYTES-1:0] keep;
        logic last;
        logic [`STREAM_CHANNEL_WIDTH-1:0] id;
        logic [`STREAM_DEST_WIDTH-1:0] dest;
        logic [`STREAM_USER_WIDTH-1:0] user;
    } beat_t;

    // Shadow of the configuration registers
    logic [`STREAM_CHANNELS-1:0] enable_model = '1;
    logic [`STREAM_DEST_WIDTH-1:0] dest_model [`STREAM_CHANNELS];
    logic [`STREAM_USER_WIDTH-1:0] user_model [`STREAM_CHANNELS];
    beat_t expected_q [$];
    int errors_at_start;
    int beats_at_start;

    function automatic logic is_route_addr(input logic [`CFG_ADDR_WIDTH-1:0] addr);
        return int'(addr) >= int'(CFG_ADDR_ROUTE_BASE) &&
               int'(addr) < int'(CFG_ADDR_ROUTE_BASE) + `STREAM_CHANNELS;
    endfunction

    // Control word has enables in 3:0, route entry has dest in 3:0 and user in 7:4
    function automatic logic [`CFG_DATA_WIDTH-1:0] expected_readback(
        input logic [`CFG_ADDR_WIDTH-1:0] addr);
        logic [`CFG_DATA_WIDTH-1:0] word;
        logic [`STREAM_CHANNEL_WIDTH-1:0] entry;
        word = '0;
        entry = 2'(addr - CFG_ADDR_ROUTE_BASE);
        if (addr == CFG_ADDR_CTRL) begin
            word[3:0] = enable_model;
        end
        else if (is_route_addr(addr)) begin
            word[3:0] = dest_model[entry];
            word[7:4] = user_model[entry];
        end
        return word;
    endfunction

    // Expected tx beat for an accepted rx beat
    // Empty counts unused bytes at the top of the word
    function automatic beat_t reference_beat(
        input logic [`STREAM_DATA_BYTES*8-1:0] data,
        input logic [`STREAM_CHANNEL_WIDTH-1:0] chan,
        input logic [`STREAM_EMPTY_WIDTH-1:0] empty,
        input logic eop);
        beat_t b;
        b.data = data;
        for (int i = 0; i < `STREAM_DATA_BYTES; i++) begin
            b.strb[i] = (i < `STREAM_DATA_BYTES - int'(empty));
        end
        b.keep = '1;
        b.last = eop;
        b.id = chan;
        b.dest = dest_model[chan];
        b.user = user_model[chan];
        return b;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, name, got, exp);
        end
    endtask

    always @(posedge aclk) begin
        beat_t exp;
        logic [`STREAM_CHANNEL_WIDTH-1:0] entry;
        if (!areset_n) begin
            // Reset values, nothing may leave the bridge
            enable_model = '1;
            for (int n = 0; n < `STREAM_CHANNELS; n++) begin
                dest_model[n] = '0;
                user_model[n] = '0;
            end
            expected_q.delete();
            compare_value("tx_tvalid", 32'(tx_tvalid), 32'd0);
        end
        else begin
            // Pop before push, a beat accepted now shows one cycle later
            if (tx_tvalid && tx_tready) begin
                if (expected_q.size() == 0) begin
                    error_count++;
                    $display("Beat on tx at %0t ns with no expected beat left", $time);
                end
                else begin
                    exp = expected_q.pop_front();
                    compare_value("tx_tdata", 32'(tx_tdata), 32'(exp.data));
                    compare_value("tx_tstrb", 32'(tx_tstrb), 32'(exp.strb));
                    compare_value("tx_tkeep", 32'(tx_tkeep), 32'(exp.keep));
                    compare_value("tx_tlast", 32'(tx_tlast), 32'(exp.last));
                    compare_value("tx_tid", 32'(tx_tid), 32'(exp.id));
                    compare_value("tx_tdest", 32'(tx_tdest), 32'(exp.dest));
                    compare_value("tx_tuser", 32'(tx_tuser), 32'(exp.user));
                    beats_compared++;
                end
            end
            // Disabled channel beats are consumed and never expected
            if (rx_valid && rx_ready && enable_model[rx_channel]) begin
                expected_q.push_back(reference_beat(rx_data, rx_channel, rx_empty,
                                                    rx_endofpacket));
            end
        end
        compare_value("rx_ready", 32'(rx_ready), 32'(tx_tready));
        compare_value("cfg_rdata", cfg_rdata, expected_readback(cfg_addr));
        // Write lands at this edge, after the readback of the old value
        if (areset_n && cfg_wr) begin
            entry = 2'(cfg_addr - CFG_ADDR_ROUTE_BASE);
            if (cfg_addr == CFG_ADDR_CTRL) begin
                enable_model = cfg_wdata[3:0];
            end
            else if (is_route_addr(cfg_addr)) begin
                dest_model[entry] = cfg_wdata[3:0];
                user_model[entry] = cfg_wdata[7:4];
            end
        end
        if (test_end) begin
            if (expected_q.size() != 0) begin
                error_count++;
                $display("Test %0d ended with %0d expected beats that never appeared",
                         test_num, expected_q.size());
                expected_q.delete();
            end
            $display("Test %0d finished: %0d beats compared, %0d errors", test_num,
                     beats_compared - beats_at_start, error_count - errors_at_start);
            beats_at_start = beats_compared;
            errors_at_start = error_count;
        end
        pending = expected_q.size();
    end

endmodule

// ==== bench/bridge_tb.sv ====
// Top of the stream bridge testbench
// Runs reset, configuration, data path, routing, channel drop and back-pressure tests
// Stimulus changes on the falling edge, bridge_checker does the comparing

`timescale 1ns/1ns

`include "stream_params.svh"

module bridge_tb import stream_pkg::*; ();
    // About 400 beats, half of them at roughly 50% tready, plus setup and drains
    localparam int CYCLE_LIMIT = 5000;

    logic aclk = 1'b1;
    logic areset_n;
    logic cfg_wr;
    logic [`CFG_ADDR_WIDTH-1:0] cfg_addr;
    cfg_word_u cfg_wdata;
    cfg_word_u cfg_rdata;
    logic rx_valid;
    logic rx_ready;
    logic [`STREAM_DATA_BYTES*8-1:0] rx_data;
    logic [`STREAM_CHANNEL_WIDTH-1:0] rx_channel;
    logic [`STREAM_EMPTY_WIDTH-1:0] rx_empty;
    logic rx_endofpacket;
    logic tx_tvalid;
    logic tx_tready;
    logic [`STREAM_DATA_BYTES*8-1:0] tx_tdata;
    logic [`STREAM_DATA_BYTES-1:0] tx_tstrb;
    logic [`STREAM_DATA_BYTES-1:0] tx_tkeep;
    logic tx_tlast;
    logic [`STREAM_CHANNEL_WIDTH-1:0] tx_tid;
    logic [`STREAM_DEST_WIDTH-1:0] tx_tdest;
    logic [`STREAM_USER_WIDTH-1:0] tx_tuser;
    logic test_end;
    int test_num;
    int error_count;
    int check_count;
    int beats_compared;
    int pending;
    int cycle_count;

    // 100 ns period, first edge is a falling one
    always #50 aclk = ~aclk;

    stream_bridge_top dut_i (.*);
    bridge_checker checker_i (.*);

    function automatic cfg_word_u route_word(input logic [3:0] dest, input logic [3:0] user);
        cfg_word_u w;
        w = '0;
        w.route.dest = dest;
        w.route.user = user;
        return w;
    endfunction

    function automatic cfg_word_u enable_word(input logic [3:0] enables);
        cfg_word_u w;
        w = '0;
        w.ctrl.channel_enable = enables;
        return w;
    endfunction

    // All tasks start and end just after a falling edge
    task automatic write_config(input logic [`CFG_ADDR_WIDTH-1:0] addr, input cfg_word_u data);
        cfg_wr = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(negedge aclk);
        cfg_wr = 1'b0;
    endtask

    task automatic read_config(input logic [`CFG_ADDR_WIDTH-1:0] addr);
        cfg_addr = addr;
        @(negedge aclk);
    endtask

    task automatic set_tready(input bit backpressure);
        tx_tready = backpressure ? 1'($urandom_range(0, 1)) : 1'b1;
    endtask

    task automatic idle_cycles(input int n, input bit backpressure);
        rx_valid = 1'b0;
        repeat (n) begin
            set_tready(backpressure);
            @(negedge aclk);
        end
    endtask

    // Holds the beat until an edge with rx_ready high takes it
    task automatic send_beat(input logic [1:0] chan, input logic eop, input bit backpressure);
        logic accepted;
        rx_valid = 1'b1;
        rx_data = $urandom;
        rx_channel = chan;
        rx_endofpacket = eop;
        rx_empty = eop ? 2'($urandom_range(0, 3)) : 2'd0;
        accepted = 1'b0;
        while (!accepted) begin
            set_tready(backpressure);
            @(posedge aclk);
            accepted = rx_ready;
            @(negedge aclk);
        end
        rx_valid = 1'b0;
    endtask

    task automatic send_packet(input logic [1:0] chan, input int len, input bit backpressure);
        for (int i = 0; i < len; i++) begin
            send_beat(chan, i == len - 1, backpressure);
            if (backpressure) begin
                idle_cycles($urandom_range(0, 2), backpressure);
            end
        end
    endtask

    // Let the output stage drain, then mark the end of the test for the checker
    task automatic finish_test(input int n);
        int waited;
        waited = 0;
        rx_valid = 1'b0;
        tx_tready = 1'b1;
        while (pending != 0 && waited < 20) begin
            @(negedge aclk);
            waited++;
        end
        test_num = n;
        test_end = 1'b1;
        @(negedge aclk);
        test_end = 1'b0;
    endtask

    initial begin
        void'($urandom(75225));
        areset_n = 1'b1;
        cfg_wr = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        rx_valid = 1'b0;
        rx_data = '0;
        rx_channel = '0;
        rx_empty = '0;
        rx_endofpacket = 1'b0;
        tx_tready = 1'b1;
        test_end = 1'b0;
        test_num = 0;

        // Test 1, reset with tready toggling and readback sweeping
        @(negedge aclk);
        areset_n = 1'b0;
        for (int i = 0; i < 16; i++) begin
            set_tready(1'b1);
            cfg_addr = 3'(i % 5);
            @(negedge aclk);
        end
        areset_n = 1'b1;
        for (int a = 0; a < 5; a++) begin
            read_config(3'(a));
        end
        finish_test(1);

        // Test 2, random words to every address including unused ones
        for (int a = 0; a < 8; a++) begin
            write_config(3'(a), $urandom);
            read_config(3'(a));
        end
        for (int a = 0; a < 8; a++) begin
            read_config(3'(a));
        end
        write_config(CFG_ADDR_CTRL, enable_word(4'hf));
        finish_test(2);

        // Test 3, packets with tready held high
        for (int p = 0; p < 30; p++) begin
            send_packet(2'($urandom_range(0, 3)), $urandom_range(1, 8), 1'b0);
        end
        finish_test(3);

        // Test 4, distinct routes and beats interleaved across channels
        for (int n = 0; n < 4; n++) begin
            write_config(CFG_ADDR_ROUTE_BASE + 3'(n), route_word(4'(3 * n + 2), 4'(12 - 2 * n)));
        end
        for (int b = 0; b < 60; b++) begin
            send_beat(2'($urandom_range(0, 3)), 1'($urandom_range(0, 1)), 1'b0);
        end
        finish_test(4);

        // Test 5, channels 1 and 3 off
        write_config(CFG_ADDR_CTRL, enable_word(4'b0101));
        for (int p = 0; p < 20; p++) begin
            send_packet(2'($urandom_range(0, 3)), $urandom_range(1, 4), 1'b0);
        end
        finish_test(5);
        write_config(CFG_ADDR_CTRL, enable_word(4'hf));

        // Test 6, random tready and random gaps between beats
        for (int p = 0; p < 30; p++) begin
            send_packet(2'($urandom_range(0, 3)), $urandom_range(1, 8), 1'b1);
        end
        finish_test(6);

        $display("Summary: 6 tests, %0d checks, %0d beats compared, %0d errors",
                 check_count, beats_compared, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end
        else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Ends a hung run
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+logic
logic/stream_pkg.sv
logic/route_config.sv
logic/avalon_to_axis.sv
logic/stream_bridge_top.sv
bench/bridge_checker.sv
bench/bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the stream bridge testbench with Verilator and run it into sim.log
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module bridge_tb -f compile.f

status=0
./obj_dir/Vbridge_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
